//--- project.f
tmu_pkg.sv
tmu_pipe_if.sv
tmu_ctlif.sv
tmu_mask.sv
tmu_clamp.sv
tmu_adrgen.sv
tmu_core.sv
tb_tmu_checker.sv
tb_tmu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
verilator --binary --timing --assert -Wno-fatal --top-module tb_tmu -f project.f -o sim_tmu \
	|| { echo "Build failed"; exit 1; }
./obj_dir/sim_tmu > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "FAIL: no result in log"; exit 1; }
echo "PASS"

//--- tb_tmu.sv
module tb_tmu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD   = 4;
	localparam int RUN_PTS      = 60;
	localparam int NUM_PTS      = 2 * RUN_PTS;
	localparam int WATCH_CYCLES = NUM_PTS * 20 + 1500; // Margin covers CSR traffic and drain.

	logic               sys_clk;
	logic               sys_rst;
	logic [13:0]        csr_a_i;
	logic               csr_we_i;
	logic [31:0]        csr_di_i;
	logic [31:0]        csr_do_o;
	logic               irq_o;
	logic               pt_stb_i;
	logic               pt_ack_o;
	logic               pt_last_i;
	logic signed [11:0] pt_dx_i;
	logic signed [11:0] pt_dy_i;
	logic signed [17:0] pt_tx_i;
	logic signed [17:0] pt_ty_i;
	logic               fetch_stb_o;
	logic               fetch_ack_i;
	logic [24:0]        fetch_dadr_o;
	logic [24:0]        fetch_tadr_o;
	logic [5:0]         fetch_xfrac_o;
	logic [5:0]         fetch_yfrac_o;
	logic               run_done;
	logic               report_done;
	int                 err_total;
	int                 seed;
	logic signed [11:0] p_dx [NUM_PTS];
	logic signed [11:0] p_dy [NUM_PTS];
	logic signed [17:0] p_tx [NUM_PTS];
	logic signed [17:0] p_ty [NUM_PTS];

	tmu_core u_dut (.*);

	tb_tmu_checker u_chk (
		.sys_clk (sys_clk), .sys_rst (sys_rst),
		.csr_a_i (csr_a_i), .csr_we_i (csr_we_i), .csr_di_i (csr_di_i), .csr_do_i (csr_do_o),
		.irq_i (irq_o),
		.pt_stb_i (pt_stb_i), .pt_ack_i (pt_ack_o), .pt_last_i (pt_last_i),
		.pt_dx_i (pt_dx_i), .pt_dy_i (pt_dy_i), .pt_tx_i (pt_tx_i), .pt_ty_i (pt_ty_i),
		.fetch_stb_i (fetch_stb_o), .fetch_ack_i (fetch_ack_i),
		.fetch_dadr_i (fetch_dadr_o), .fetch_tadr_i (fetch_tadr_o),
		.fetch_xfrac_i (fetch_xfrac_o), .fetch_yfrac_i (fetch_yfrac_o),
		.run_done_i (run_done), .report_done_o (report_done), .err_total_o (err_total)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(WATCH_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, the run never finished", WATCH_CYCLES);
		$display("Test failed");
		$finish;
	end

	// Random back-pressure on the fetch port, low about one cycle in four.
	initial begin
		fetch_ack_i = 1'b0;
		forever begin
			@(posedge sys_clk);
			fetch_ack_i <= ($random(seed) & 3) != 0;
		end
	end

	// **************************************************
	// Stimulus tasks.
	// **************************************************
	task automatic csr_write(input logic [3:0] idx, input logic [31:0] val);
		@(posedge sys_clk);
		csr_a_i  <= {tmu_pkg::CSR_BLOCK, 6'd0, idx};
		csr_we_i <= 1'b1;
		csr_di_i <= val;
		@(posedge sys_clk);
		csr_a_i  <= '0;
		csr_we_i <= 1'b0;
	endtask

	task automatic csr_read(input logic [3:0] idx);
		@(posedge sys_clk);
		csr_a_i <= {tmu_pkg::CSR_BLOCK, 6'd0, idx};
		@(posedge sys_clk);
		csr_a_i <= '0; // Another block, so no read is checked.
	endtask

	task automatic program_run(input logic [17:0] hmask, input logic [17:0] vmask);
		int r;
		csr_write(tmu_pkg::REG_TEX_HMASK, 32'(hmask));
		csr_write(tmu_pkg::REG_TEX_VMASK, 32'(vmask));
		csr_write(tmu_pkg::REG_TEX_FBUF, 32'h0004_0000);
		csr_write(tmu_pkg::REG_TEX_HRES, 32'd16);
		csr_write(tmu_pkg::REG_TEX_VRES, 32'd16);
		csr_write(tmu_pkg::REG_DST_FBUF, 32'h0010_0000);
		csr_write(tmu_pkg::REG_DST_HRES, 32'd40);
		csr_write(tmu_pkg::REG_DST_VRES, 32'd30);
		for (r = 1; r <= 8; r++)
			csr_read(4'(r));
	endtask

	task automatic make_points();
		int k;
		for (k = 0; k < NUM_PTS; k++) begin
			p_dx[k] = 12'($unsigned($random(seed)) % 40);
			p_dy[k] = 12'($unsigned($random(seed)) % 30);
			p_tx[k] = 18'($random(seed));
			p_ty[k] = 18'($random(seed));
			if (k >= RUN_PTS) begin
				case (k % 5) // The second run also aims outside the frame.
					0: p_dx[k] = -p_dx[k] - 12'sd1;
					1: p_dx[k] = p_dx[k] + 12'sd40;
					2: p_dy[k] = p_dy[k] + 12'sd30;
					default: ;
				endcase
			end
		end
	endtask

	// Returns once the point is acknowledged, so the next edge takes it.
	task automatic send_point(input int k, input logic last);
		@(posedge sys_clk);
		pt_stb_i  <= 1'b1;
		pt_last_i <= last;
		pt_dx_i   <= p_dx[k];
		pt_dy_i   <= p_dy[k];
		pt_tx_i   <= p_tx[k];
		pt_ty_i   <= p_ty[k];
		@(negedge sys_clk);
		while (!pt_ack_o)
			@(negedge sys_clk);
	endtask

	task automatic run_points(input int first);
		int k;
		csr_write(tmu_pkg::REG_CTRL, 32'd1);
		csr_read(tmu_pkg::REG_CTRL);
		for (k = first; k < first + RUN_PTS; k++)
			send_point(k, k == first + RUN_PTS - 1);
		@(posedge sys_clk);
		pt_stb_i  <= 1'b0;
		pt_last_i <= 1'b0;
		@(negedge sys_clk);
		while (!irq_o)
			@(negedge sys_clk);
		csr_read(tmu_pkg::REG_CTRL); // Busy is low again after the interrupt.
	endtask

	// Offers a point while idle; it must not be taken.
	task automatic probe_idle();
		@(posedge sys_clk);
		pt_stb_i <= 1'b1;
		repeat (8) @(posedge sys_clk);
		pt_stb_i <= 1'b0;
	endtask

	initial begin
		sys_rst   = 1'b1;
		csr_a_i   = '0;
		csr_we_i  = 1'b0;
		csr_di_i  = '0;
		pt_stb_i  = 1'b0;
		pt_last_i = 1'b0;
		pt_dx_i   = '0;
		pt_dy_i   = '0;
		pt_tx_i   = '0;
		pt_ty_i   = '0;
		run_done  = 1'b0;
		seed      = 32'h781b;
		make_points();
		repeat (10) @(posedge sys_clk);
		sys_rst <= 1'b0;
		csr_read(tmu_pkg::REG_CTRL);
		program_run(18'h003ff, 18'h001ff); // Wrap at 16 columns and 8 rows.
		run_points(0);
		probe_idle();
		program_run(18'h3ffff, 18'h3ffff); // Masks keep every bit, so clamping does the work.
		run_points(RUN_PTS);
		probe_idle();
		@(posedge sys_clk);
		run_done <= 1'b1;
		@(negedge sys_clk);
		while (!report_done)
			@(negedge sys_clk);
		if (err_total == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tb_tmu_checker.sv
module tb_tmu_checker (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic [13:0]         csr_a_i,
	input  logic                csr_we_i,
	input  logic [31:0]         csr_di_i,
	input  logic [31:0]         csr_do_i,
	input  logic                irq_i,
	input  logic                pt_stb_i,
	input  logic                pt_ack_i,
	input  logic                pt_last_i,
	input  logic signed [11:0]  pt_dx_i,
	input  logic signed [11:0]  pt_dy_i,
	input  logic signed [17:0]  pt_tx_i,
	input  logic signed [17:0]  pt_ty_i,
	input  logic                fetch_stb_i,
	input  logic                fetch_ack_i,
	input  logic [24:0]         fetch_dadr_i,
	input  logic [24:0]         fetch_tadr_i,
	input  logic [5:0]          fetch_xfrac_i,
	input  logic [5:0]          fetch_yfrac_i,
	input  logic                run_done_i,
	output logic                report_done_o,
	output int                  err_total_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [31:0] shadow [0:15];  // Register values as the CSR writes left them.
	logic [61:0] exp_q [$];      // Expected {dadr, tadr, xfrac, yfrac}, oldest first.
	logic [61:0] exp_item;
	logic [31:0] rd_exp;
	logic        rd_pend;
	logic        busy_exp;
	logic        last_seen;
	logic        csr_hit;
	logic [3:0]  csr_idx;
	int          err_value;
	int          err_other;
	int          n_checked;
	int          n_starts;
	int          n_irqs;

	assign csr_hit = (csr_a_i[13:10] == tmu_pkg::CSR_BLOCK);
	assign csr_idx = csr_a_i[3:0];

	// Bits that each register keeps.
	function automatic logic [31:0] reg_mask(input logic [3:0] idx);
		case (idx)
			tmu_pkg::REG_TEX_HMASK, tmu_pkg::REG_TEX_VMASK: return 32'h0003_ffff;
			tmu_pkg::REG_TEX_FBUF, tmu_pkg::REG_DST_FBUF:   return 32'h01ff_ffff;
			tmu_pkg::REG_TEX_HRES, tmu_pkg::REG_TEX_VRES,
			tmu_pkg::REG_DST_HRES, tmu_pkg::REG_DST_VRES:   return 32'h0000_07ff;
			default: return 32'h0;
		endcase
	endfunction

	// **************************************************
	// Reference model that masks, clamps or drops a point and forms its addresses.
	// **************************************************
	function automatic bit expect_fetch(
		input  logic signed [11:0] dx,
		input  logic signed [11:0] dy,
		input  logic signed [17:0] tx,
		input  logic signed [17:0] ty,
		output logic [61:0]        item
	);
		logic signed [17:0] tx_m;
		logic signed [17:0] ty_m;
		longint             tx_c;
		longint             ty_c;
		longint             lim_x;
		longint             lim_y;
		longint             dadr;
		longint             tadr;
		tx_m = tx & shadow[tmu_pkg::REG_TEX_HMASK][17:0];
		ty_m = ty & shadow[tmu_pkg::REG_TEX_VMASK][17:0];
		item = '0;
		if (dx < 0 || dy < 0 || int'(dx) >= int'(shadow[tmu_pkg::REG_DST_HRES])
			|| int'(dy) >= int'(shadow[tmu_pkg::REG_DST_VRES]))
			return 1'b0; // Outside the destination frame.
		lim_x = (longint'(shadow[tmu_pkg::REG_TEX_HRES]) - 1) * 64;
		lim_y = (longint'(shadow[tmu_pkg::REG_TEX_VRES]) - 1) * 64;
		tx_c  = (tx_m < 0) ? 0 : longint'(tx_m);
		ty_c  = (ty_m < 0) ? 0 : longint'(ty_m);
		if (tx_c > lim_x)
			tx_c = lim_x;
		if (ty_c > lim_y)
			ty_c = lim_y;
		dadr = longint'(shadow[tmu_pkg::REG_DST_FBUF])
			+ longint'(dy) * longint'(shadow[tmu_pkg::REG_DST_HRES]) + longint'(dx);
		tadr = longint'(shadow[tmu_pkg::REG_TEX_FBUF])
			+ (ty_c / 64) * longint'(shadow[tmu_pkg::REG_TEX_HRES]) + tx_c / 64;
		item = {dadr[24:0], tadr[24:0], tx_c[5:0], ty_c[5:0]}; // Addresses wrap at 25 bits.
		return 1'b1;
	endfunction

	task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		err_value++;
		$display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_fault(input string msg);
		err_other++;
		$display("Check failed at %0d ns: %s", $time, msg);
	endtask

	// Everything is sampled on the falling edge, half a cycle clear of the DUT.
	always @(negedge sys_clk) begin
		if (sys_rst) begin
			foreach (shadow[r])
				shadow[r] = '0;
			exp_q.delete();
			{rd_pend, busy_exp, last_seen, report_done_o} = '0;
			{err_value, err_other, n_checked, n_starts, n_irqs, err_total_o} = '0;
		end else if (!report_done_o) begin
			if (rd_pend && csr_do_i !== rd_exp)
				report_value("csr_do_o", csr_do_i, rd_exp);
			if (irq_i) begin
				if (!last_seen)
					report_fault("interrupt without a finished run");
				if (exp_q.size() != 0)
					report_fault($sformatf("interrupt with %0d fetches still due", exp_q.size()));
				n_irqs++;
				last_seen = 1'b0;
				busy_exp  = 1'b0;
			end
			rd_pend = csr_hit && !csr_we_i;
			rd_exp  = (csr_idx == tmu_pkg::REG_CTRL) ? {31'd0, busy_exp} : shadow[csr_idx];
			if (pt_ack_i && !busy_exp)
				report_fault("pt_ack_o is high while the unit is idle");
			if (pt_stb_i && pt_ack_i) begin
				if (expect_fetch(pt_dx_i, pt_dy_i, pt_tx_i, pt_ty_i, exp_item))
					exp_q.push_back(exp_item);
				if (pt_last_i)
					last_seen = 1'b1;
			end
			if (fetch_stb_i && fetch_ack_i) begin
				if (exp_q.size() == 0) begin
					report_fault("fetch request with no point expected");
				end else begin
					exp_item = exp_q.pop_front();
					n_checked++;
					if (fetch_dadr_i !== exp_item[61:37])
						report_value("fetch_dadr_o", 32'(fetch_dadr_i), 32'(exp_item[61:37]));
					if (fetch_tadr_i !== exp_item[36:12])
						report_value("fetch_tadr_o", 32'(fetch_tadr_i), 32'(exp_item[36:12]));
					if (fetch_xfrac_i !== exp_item[11:6])
						report_value("fetch_xfrac_o", 32'(fetch_xfrac_i), 32'(exp_item[11:6]));
					if (fetch_yfrac_i !== exp_item[5:0])
						report_value("fetch_yfrac_o", 32'(fetch_yfrac_i), 32'(exp_item[5:0]));
				end
			end
			if (csr_hit && csr_we_i) begin
				if (csr_idx != tmu_pkg::REG_CTRL)
					shadow[csr_idx] = csr_di_i & reg_mask(csr_idx);
				else if (csr_di_i[0] && !busy_exp) begin
					busy_exp = 1'b1; // A start is only taken while idle.
					n_starts++;
				end
			end
			if (run_done_i) begin
				if (exp_q.size() != 0)
					report_fault($sformatf("%0d fetch requests never arrived", exp_q.size()));
				if (n_irqs != n_starts)
					report_fault($sformatf("%0d runs started, %0d interrupts", n_starts, n_irqs));
				$display("Checker summary: %0d value errors, %0d other errors, %0d fetches compared",
					err_value, err_other, n_checked);
				err_total_o   = err_value + err_other;
				report_done_o = 1'b1;
			end
		end
	end

endmodule

//--- tmu_core.sv
module tmu_core (
	input  logic                               sys_clk,
	input  logic                               sys_rst,
	input  logic [13:0]                        csr_a_i,
	input  logic                               csr_we_i,
	input  logic [31:0]                        csr_di_i,
	output logic [31:0]                        csr_do_o,
	output logic                               irq_o,
	input  logic                               pt_stb_i,
	output logic                               pt_ack_o,
	input  logic                               pt_last_i,
	input  logic signed [tmu_pkg::POS_W-1:0]   pt_dx_i,
	input  logic signed [tmu_pkg::POS_W-1:0]   pt_dy_i,
	input  logic signed [tmu_pkg::FP_W-1:0]    pt_tx_i,
	input  logic signed [tmu_pkg::FP_W-1:0]    pt_ty_i,
	output logic                               fetch_stb_o,
	input  logic                               fetch_ack_i,
	output logic [tmu_pkg::ADR_W-1:0]          fetch_dadr_o,
	output logic [tmu_pkg::ADR_W-1:0]          fetch_tadr_o,
	output logic [tmu_pkg::FRAC_W-1:0]         fetch_xfrac_o,
	output logic [tmu_pkg::FRAC_W-1:0]         fetch_yfrac_o
);

	tmu_pkg::tmu_cfg_t cfg;
	logic              mask_busy;
	logic              clamp_busy;
	logic              adrgen_busy;

	// **************************************************
	// Streams between the stages.
	// **************************************************
	tmu_pipe_if #(.payload_t(tmu_pkg::tmu_point_t))   pt_in ();
	tmu_pipe_if #(.payload_t(tmu_pkg::tmu_point_t))   pt_mask ();
	tmu_pipe_if #(.payload_t(tmu_pkg::tmu_clamped_t)) pt_clamp ();

	tmu_ctlif u_ctlif (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a_i      (csr_a_i),
		.csr_we_i     (csr_we_i),
		.csr_di_i     (csr_di_i),
		.csr_do_o     (csr_do_o),
		.irq_o        (irq_o),
		.pt_stb_i     (pt_stb_i),
		.pt_ack_o     (pt_ack_o),
		.pt_last_i    (pt_last_i),
		.pt_dx_i      (pt_dx_i),
		.pt_dy_i      (pt_dy_i),
		.pt_tx_i      (pt_tx_i),
		.pt_ty_i      (pt_ty_i),
		.stage_busy_i ({adrgen_busy, clamp_busy, mask_busy}),
		.pt_out       (pt_in),
		.cfg_o        (cfg)
	);

	tmu_mask u_mask (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.cfg_i   (cfg),
		.pt_in   (pt_in),
		.pt_out  (pt_mask),
		.busy_o  (mask_busy)
	);

	tmu_clamp u_clamp (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.cfg_i   (cfg),
		.pt_in   (pt_mask),
		.pt_out  (pt_clamp),
		.busy_o  (clamp_busy)
	);

	tmu_adrgen u_adrgen (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.cfg_i         (cfg),
		.pt_in         (pt_clamp),
		.busy_o        (adrgen_busy),
		.fetch_stb_o   (fetch_stb_o),
		.fetch_ack_i   (fetch_ack_i),
		.fetch_dadr_o  (fetch_dadr_o),
		.fetch_tadr_o  (fetch_tadr_o),
		.fetch_xfrac_o (fetch_xfrac_o),
		.fetch_yfrac_o (fetch_yfrac_o)
	);

endmodule

//--- tmu_adrgen.sv
module tmu_adrgen (
	input  logic                        sys_clk,
	input  logic                        sys_rst,
	input  tmu_pkg::tmu_cfg_t           cfg_i,
	tmu_pipe_if.sink                    pt_in,
	output logic                        busy_o,
	output logic                        fetch_stb_o,
	input  logic                        fetch_ack_i,
	output logic [tmu_pkg::ADR_W-1:0]   fetch_dadr_o,
	output logic [tmu_pkg::ADR_W-1:0]   fetch_tadr_o,
	output logic [tmu_pkg::FRAC_W-1:0]  fetch_xfrac_o,
	output logic [tmu_pkg::FRAC_W-1:0]  fetch_yfrac_o
);

	localparam int PROD_W = 2 * tmu_pkg::RES_W;

	// **************************************************
	// Stage 1 forms the row products.
	// **************************************************
	logic                        s1_valid;
	logic                        s1_ack;
	logic [PROD_W-1:0]           s1_drow;   // dy * dst_hres.
	logic [PROD_W-1:0]           s1_trow;   // Integer part of ty times tex_hres.
	logic [tmu_pkg::RES_W-1:0]   s1_dx;
	logic [tmu_pkg::RES_W-1:0]   s1_tcol;
	logic [tmu_pkg::FRAC_W-1:0]  s1_xfrac;
	logic [tmu_pkg::FRAC_W-1:0]  s1_yfrac;

	assign s1_ack    = ~fetch_stb_o | fetch_ack_i;
	assign pt_in.ack = ~s1_valid | s1_ack;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			s1_valid <= 1'b0;
		else if (pt_in.ack)
			s1_valid <= pt_in.stb;
	end

	always_ff @(posedge sys_clk) begin
		if (pt_in.stb & pt_in.ack) begin
			s1_drow  <= pt_in.data.dy * cfg_i.dst_hres;
			s1_trow  <= pt_in.data.ty[tmu_pkg::FP_W-2:tmu_pkg::FRAC_W] * cfg_i.tex_hres;
			s1_dx    <= pt_in.data.dx;
			s1_tcol  <= pt_in.data.tx[tmu_pkg::FP_W-2:tmu_pkg::FRAC_W];
			s1_xfrac <= pt_in.data.tx[tmu_pkg::FRAC_W-1:0];
			s1_yfrac <= pt_in.data.ty[tmu_pkg::FRAC_W-1:0];
		end
	end

	// **************************************************
	// Stage 2 adds up the final addresses.
	// **************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			fetch_stb_o <= 1'b0;
		else if (s1_ack)
			fetch_stb_o <= s1_valid;
	end

	always_ff @(posedge sys_clk) begin
		if (s1_valid & s1_ack) begin
			fetch_dadr_o  <= cfg_i.dst_fbuf + tmu_pkg::ADR_W'(s1_drow)
				+ tmu_pkg::ADR_W'(s1_dx); // Wraps at ADR_W bits.
			fetch_tadr_o  <= cfg_i.tex_fbuf + tmu_pkg::ADR_W'(s1_trow)
				+ tmu_pkg::ADR_W'(s1_tcol);
			fetch_xfrac_o <= s1_xfrac;
			fetch_yfrac_o <= s1_yfrac;
		end
	end

	assign busy_o = s1_valid | fetch_stb_o;

	a_fetch_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fetch_stb_o && !fetch_ack_i |=> fetch_stb_o
		&& $stable({fetch_dadr_o, fetch_tadr_o, fetch_xfrac_o, fetch_yfrac_o}));

endmodule

//--- tmu_clamp.sv
module tmu_clamp (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  tmu_pkg::tmu_cfg_t cfg_i,
	tmu_pipe_if.sink          pt_in,
	tmu_pipe_if.source        pt_out,
	output logic              busy_o
);

	logic                  valid;
	logic                  off_frame;
	tmu_pkg::tmu_clamped_t pt_q;

	// Limits one texture coordinate to the range 0 to (res - 1) * 64.
	function automatic logic [tmu_pkg::FP_W-2:0] clamp_coord(
		input logic [tmu_pkg::FP_W-1:0]  t,
		input logic [tmu_pkg::RES_W-1:0] res
	);
		logic [tmu_pkg::FP_W-2:0] t_max;
		t_max = {res - 1'b1, {tmu_pkg::FRAC_W{1'b0}}};
		if (t[tmu_pkg::FP_W-1])
			return '0;
		else if (t[tmu_pkg::FP_W-2:0] > t_max)
			return t_max;
		else
			return t[tmu_pkg::FP_W-2:0];
	endfunction

	// A non-negative position has a clear top bit, so its low bits compare exactly.
	assign off_frame = pt_in.data.dx[tmu_pkg::POS_W-1]
		| pt_in.data.dy[tmu_pkg::POS_W-1]
		| (pt_in.data.dx[tmu_pkg::RES_W-1:0] >= cfg_i.dst_hres)
		| (pt_in.data.dy[tmu_pkg::RES_W-1:0] >= cfg_i.dst_vres);

	assign pt_in.ack = ~valid | pt_out.ack;

	// A dropped point is acknowledged but never enters the slot.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (pt_in.ack)
			valid <= pt_in.stb & ~off_frame;
	end

	always_ff @(posedge sys_clk) begin
		if (pt_in.stb & pt_in.ack) begin
			pt_q <= '{
				dx: pt_in.data.dx[tmu_pkg::RES_W-1:0],
				dy: pt_in.data.dy[tmu_pkg::RES_W-1:0],
				tx: clamp_coord(pt_in.data.tx, cfg_i.tex_hres),
				ty: clamp_coord(pt_in.data.ty, cfg_i.tex_vres)
			};
		end
	end

	assign pt_out.stb  = valid;
	assign pt_out.data = pt_q;
	assign busy_o      = valid;

	// Everything passed on lies inside the destination frame set up by the CSR block.
	a_in_frame: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pt_out.stb |-> (pt_out.data.dx < cfg_i.dst_hres) && (pt_out.data.dy < cfg_i.dst_vres));

endmodule

//--- tmu_mask.sv
module tmu_mask (
	input  logic              sys_clk,
	input  logic              sys_rst,
	input  tmu_pkg::tmu_cfg_t cfg_i,
	tmu_pipe_if.sink          pt_in,
	tmu_pipe_if.source        pt_out,
	output logic              busy_o
);

	logic                valid;
	tmu_pkg::tmu_point_t pt_q;

	// The slot is free when empty or when its point leaves this cycle.
	assign pt_in.ack = ~valid | pt_out.ack;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (pt_in.ack)
			valid <= pt_in.stb;
	end

	// Wrap masks apply to the whole fixed-point word, fraction included.
	always_ff @(posedge sys_clk) begin
		if (pt_in.stb & pt_in.ack) begin
			pt_q <= '{
				dx: pt_in.data.dx,
				dy: pt_in.data.dy,
				tx: pt_in.data.tx & cfg_i.tex_hmask,
				ty: pt_in.data.ty & cfg_i.tex_vmask
			};
		end
	end

	assign pt_out.stb  = valid;
	assign pt_out.data = pt_q;
	assign busy_o      = valid;

	// A stalled output must not move until the next stage takes it.
	a_hold_stalled: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pt_out.stb && !pt_out.ack |=> pt_out.stb && $stable(pt_out.data));

endmodule

//--- tmu_ctlif.sv
module tmu_ctlif (
	input  logic                               sys_clk,
	input  logic                               sys_rst,
	input  logic [13:0]                        csr_a_i,
	input  logic                               csr_we_i,
	input  logic [31:0]                        csr_di_i,
	output logic [31:0]                        csr_do_o,
	output logic                               irq_o,
	input  logic                               pt_stb_i,
	output logic                               pt_ack_o,
	input  logic                               pt_last_i,
	input  logic signed [tmu_pkg::POS_W-1:0]   pt_dx_i,
	input  logic signed [tmu_pkg::POS_W-1:0]   pt_dy_i,
	input  logic signed [tmu_pkg::FP_W-1:0]    pt_tx_i,
	input  logic signed [tmu_pkg::FP_W-1:0]    pt_ty_i,
	input  logic [2:0]                         stage_busy_i,
	tmu_pipe_if.source                         pt_out,
	output tmu_pkg::tmu_cfg_t                  cfg_o
);

	logic [1:0] state;
	logic [1:0] next_state;
	logic       csr_sel;
	logic [3:0] reg_idx;
	logic       start;
	logic       running;
	logic       pt_accept;
	logic       drained;

	assign csr_sel = (csr_a_i[13:10] == tmu_pkg::CSR_BLOCK);
	assign reg_idx = csr_a_i[3:0];
	assign start   = csr_sel & csr_we_i & (reg_idx == tmu_pkg::REG_CTRL) & csr_di_i[0];
	assign running = (state == tmu_pkg::ST_RUN);
	assign drained = (state == tmu_pkg::ST_DRAIN) & ~|stage_busy_i;

	// **************************************************
	// Input stream gating.
	// **************************************************
	assign pt_out.stb  = running & pt_stb_i;
	assign pt_out.data = '{dx: pt_dx_i, dy: pt_dy_i, tx: pt_tx_i, ty: pt_ty_i};
	assign pt_ack_o    = running & pt_out.ack; // Nothing is taken outside a run.
	assign pt_accept   = pt_stb_i & pt_ack_o;

	always_comb begin
		next_state = state;
		case (state)
			tmu_pkg::ST_IDLE: begin
				if (start)
					next_state = tmu_pkg::ST_RUN;
			end
			tmu_pkg::ST_RUN: begin
				if (pt_accept & pt_last_i)
					next_state = tmu_pkg::ST_DRAIN;
			end
			tmu_pkg::ST_DRAIN: begin
				if (drained)
					next_state = tmu_pkg::ST_IDLE; // Last point has left the fetch port.
			end
			default: next_state = tmu_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::ST_IDLE;
			irq_o <= 1'b0;
		end else begin
			state <= next_state;
			irq_o <= drained; // High for the single cycle of the DRAIN to IDLE step.
		end
	end

	// **************************************************
	// Register file.
	// **************************************************
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cfg_o <= '0;
		end else if (csr_sel & csr_we_i) begin
			case (reg_idx)
				tmu_pkg::REG_TEX_HMASK: cfg_o.tex_hmask <= csr_di_i[tmu_pkg::FP_W-1:0];
				tmu_pkg::REG_TEX_VMASK: cfg_o.tex_vmask <= csr_di_i[tmu_pkg::FP_W-1:0];
				tmu_pkg::REG_TEX_FBUF:  cfg_o.tex_fbuf  <= csr_di_i[tmu_pkg::ADR_W-1:0];
				tmu_pkg::REG_TEX_HRES:  cfg_o.tex_hres  <= csr_di_i[tmu_pkg::RES_W-1:0];
				tmu_pkg::REG_TEX_VRES:  cfg_o.tex_vres  <= csr_di_i[tmu_pkg::RES_W-1:0];
				tmu_pkg::REG_DST_FBUF:  cfg_o.dst_fbuf  <= csr_di_i[tmu_pkg::ADR_W-1:0];
				tmu_pkg::REG_DST_HRES:  cfg_o.dst_hres  <= csr_di_i[tmu_pkg::RES_W-1:0];
				tmu_pkg::REG_DST_VRES:  cfg_o.dst_vres  <= csr_di_i[tmu_pkg::RES_W-1:0];
				default: ;
			endcase
		end
	end

	// Read data is registered, so it follows the address by one cycle.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= '0;
		end else begin
			csr_do_o <= '0;
			if (csr_sel) begin
				case (reg_idx)
					tmu_pkg::REG_CTRL:      csr_do_o <= {31'd0, state != tmu_pkg::ST_IDLE};
					tmu_pkg::REG_TEX_HMASK: csr_do_o <= 32'(cfg_o.tex_hmask);
					tmu_pkg::REG_TEX_VMASK: csr_do_o <= 32'(cfg_o.tex_vmask);
					tmu_pkg::REG_TEX_FBUF:  csr_do_o <= 32'(cfg_o.tex_fbuf);
					tmu_pkg::REG_TEX_HRES:  csr_do_o <= 32'(cfg_o.tex_hres);
					tmu_pkg::REG_TEX_VRES:  csr_do_o <= 32'(cfg_o.tex_vres);
					tmu_pkg::REG_DST_FBUF:  csr_do_o <= 32'(cfg_o.dst_fbuf);
					tmu_pkg::REG_DST_HRES:  csr_do_o <= 32'(cfg_o.dst_hres);
					tmu_pkg::REG_DST_VRES:  csr_do_o <= 32'(cfg_o.dst_vres);
					default: csr_do_o <= '0;
				endcase
			end
		end
	end

endmodule

//--- tmu_pipe_if.sv
// Point stream between two pipeline stages.
// A transfer happens on a rising edge where stb and ack are both high.
interface tmu_pipe_if #(
	parameter type payload_t = tmu_pkg::tmu_point_t
);

	logic     stb;  // Data is valid.
	logic     ack;  // Receiver takes the data this cycle.
	payload_t data;

	// The source holds stb and data steady until it sees ack.
	modport source (
		output stb,
		output data,
		input  ack
	);

	modport sink (
		input  stb,
		input  data,
		output ack
	);

endinterface

//--- tmu_pkg.sv
package tmu_pkg;

	// **************************************************
	// Fixed-point and address widths.
	// **************************************************
	localparam int FP_W   = 18; // 1 sign, 11 integer and 6 fractional bits.
	localparam int FRAC_W = 6;
	localparam int POS_W  = 12; // Signed destination position.
	localparam int RES_W  = 11; // Resolution and clamped position.
	localparam int ADR_W  = 25; // Address of a 16-bit word.

	// CSR block number, compared against csr_a bits 13 to 10.
	localparam logic [3:0] CSR_BLOCK = 4'h2;

	// Register map, in words.
	localparam logic [3:0] REG_CTRL      = 4'd0;
	localparam logic [3:0] REG_TEX_HMASK = 4'd1;
	localparam logic [3:0] REG_TEX_VMASK = 4'd2;
	localparam logic [3:0] REG_TEX_FBUF  = 4'd3;
	localparam logic [3:0] REG_TEX_HRES  = 4'd4;
	localparam logic [3:0] REG_TEX_VRES  = 4'd5;
	localparam logic [3:0] REG_DST_FBUF  = 4'd6;
	localparam logic [3:0] REG_DST_HRES  = 4'd7;
	localparam logic [3:0] REG_DST_VRES  = 4'd8;

	// Run states of the control block.
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_RUN   = 2'd1;
	localparam logic [1:0] ST_DRAIN = 2'd2;

	typedef struct packed {
		logic signed [POS_W-1:0] dx;
		logic signed [POS_W-1:0] dy;
		logic signed [FP_W-1:0]  tx;
		logic signed [FP_W-1:0]  ty;
	} tmu_point_t;

	// Coordinates after clamping are never negative.
	typedef struct packed {
		logic [RES_W-1:0] dx;
		logic [RES_W-1:0] dy;
		logic [FP_W-2:0]  tx;
		logic [FP_W-2:0]  ty;
	} tmu_clamped_t;

	typedef struct packed {
		logic [FP_W-1:0]  tex_hmask;
		logic [FP_W-1:0]  tex_vmask;
		logic [ADR_W-1:0] tex_fbuf;
		logic [RES_W-1:0] tex_hres;
		logic [RES_W-1:0] tex_vres;
		logic [ADR_W-1:0] dst_fbuf;
		logic [RES_W-1:0] dst_hres;
		logic [RES_W-1:0] dst_vres;
	} tmu_cfg_t;

endpackage
